//--- bench/router_tb.sv
// Router core testbench

`timescale 1ns/100ps
`default_nettype none

`include "router_params.svh"

module router_tb
    import router_csr_pkg::*;
();

    localparam int NI    = `ROUTER_NUM_ING;
    localparam int NE    = `ROUTER_NUM_EGR;
    localparam int DW    = `ROUTER_DATA_W;
    localparam int PW    = `ROUTER_PORT_W;
    localparam int NGRP  = 9;
    localparam int LIMIT = 1000;

    // One packet: group, ingress port, beats, table entry, egress stall
    typedef struct {
        int grp;
        int port;
        int len;
        bit en;
        int egr;
        bit stall;
    } pkt_row_t;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic [NI-1:0][DW-1:0] ing_data;
    logic [NI-1:0]         ing_last;
    logic [NI-1:0]         ing_valid;
    logic [NI-1:0]         ing_ready;
    logic [NE-1:0][DW-1:0] egr_data;
    logic [NE-1:0]         egr_last;
    logic [NE-1:0]         egr_valid;
    logic [NE-1:0]         egr_ready = '0;
    logic                  csr_wr;
    logic                  csr_rd;
    logic [3:0]            csr_addr;
    logic [DW-1:0]         csr_wdata;
    logic [DW-1:0]         csr_rdata;
    logic                  csr_rvalid;

    pkt_row_t    rows [32];
    int          nrows;
    // Scoreboard, one queue per egress and source port, {last, data}
    logic [DW:0] exp_q [NE*NI][$];
    int          exp_egr [NE];
    int          exp_drop [NI];
    int          seed = 71687;
    int          errors;
    int          timeouts;
    bit          stall_egr;
    bit          alt_on;
    bit          in_pkt [NE];
    bit          prev_ok [NE];
    int          prev_src [NE];
    int          cur_src [NE];
    int          mon_row;
    int          mon_src;
    logic [DW:0] mon_exp;

    router_top dut (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .ing_data   ( ing_data   ),
        .ing_last   ( ing_last   ),
        .ing_valid  ( ing_valid  ),
        .ing_ready  ( ing_ready  ),
        .egr_data   ( egr_data   ),
        .egr_last   ( egr_last   ),
        .egr_valid  ( egr_valid  ),
        .egr_ready  ( egr_ready  ),
        .csr_wr     ( csr_wr     ),
        .csr_rd     ( csr_rd     ),
        .csr_addr   ( csr_addr   ),
        .csr_wdata  ( csr_wdata  ),
        .csr_rdata  ( csr_rdata  ),
        .csr_rvalid ( csr_rvalid )
    );

    always #5 clk = ~clk;

    // Random egress back-pressure, all ports held off during the fill test
    always @(posedge clk) begin
        for (int e = 0; e < NE; e++) begin
            egr_ready[e] <= !stall_egr && (($random(seed) & 3) != 0);
        end
    end

    //////////////////////////////
    // Helpers

    task automatic log_failure(input string msg);
        errors++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    task automatic add_row(input int grp, input int port, input int len,
                           input bit en, input int egr, input bit stall);
        rows[nrows] = '{grp, port, len, en, egr, stall};
        nrows++;
    endtask

    // Packet number in the upper half, beat index in the lower half
    function automatic logic [DW-1:0] beat_word(input int row, input int beat);
        return DW'((row << 16) | beat);
    endfunction

    function automatic int beats_pending();
        int n;
        n = 0;
        for (int i = 0; i < NE*NI; i++) begin
            n += exp_q[i].size();
        end
        return n;
    endfunction

    task automatic csr_write(input csr_addr_e addr, input logic [DW-1:0] wdata);
        @(posedge clk);
        csr_wr    <= 1'b1;
        csr_addr  <= addr;
        csr_wdata <= wdata;
        @(posedge clk);
        csr_wr    <= 1'b0;
    endtask

    // Read data is due exactly one cycle after the strobe
    task automatic csr_check(input csr_addr_e addr, input logic [DW-1:0] exp,
                             input string what);
        @(posedge clk);
        csr_rd   <= 1'b1;
        csr_addr <= addr;
        @(posedge clk);
        csr_rd   <= 1'b0;
        @(negedge clk);
        assert (csr_rvalid)
            else log_failure($sformatf("%s read valid missing", what));
        assert (csr_rdata == exp)
            else log_failure($sformatf("%s reads 0x%0h, expected 0x%0h", what, csr_rdata, exp));
    endtask

    task automatic check_counters();
        for (int e = 0; e < NE; e++) begin
            csr_check(csr_addr_e'(EGR_CNT0 + e), DW'(exp_egr[e]),
                      $sformatf("egress %0d packet count", e));
        end
        for (int p = 0; p < NI; p++) begin
            csr_check(csr_addr_e'(DROP_CNT0 + p), DW'(exp_drop[p]),
                      $sformatf("ingress %0d drop count", p));
        end
    endtask

    task automatic wait_drain(input int g);
        int cycles;
        cycles = 0;
        while (beats_pending() != 0 && cycles < LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (beats_pending() != 0) begin
            $display("Timeout: %0d beats of group %0d never reached the egress",
                     beats_pending(), g);
            timeouts++;
        end
    endtask

    //////////////////////////////
    // Packet group driver

    task automatic run_group(input int g);
        int prow [NI][32];
        int pcnt [NI];
        int pidx [NI];
        int beat [NI];
        bit port_fwd [NI];
        int p;
        int r;
        int entry;
        int cycles;
        int accepted;
        int fwd_ports;
        bit finished;
        for (int i = 0; i < NI; i++) begin
            pcnt[i]     = 0;
            pidx[i]     = 0;
            beat[i]     = 0;
            port_fwd[i] = 1'b0;
        end
        // Program the table and fill the scoreboard from the row rule
        for (int i = 0; i < nrows; i++) begin
            if (rows[i].grp == g) begin
                p = rows[i].port;
                prow[p][pcnt[p]] = i;
                pcnt[p]++;
                entry = rows[i].egr + (rows[i].en ? (1 << PW) : 0);
                csr_write(csr_addr_e'(FWD_ING0 + p), DW'(entry));
                csr_check(csr_addr_e'(FWD_ING0 + p), DW'(entry),
                          $sformatf("forwarding entry %0d", p));
                if (rows[i].en) begin
                    for (int b = 0; b < rows[i].len; b++) begin
                        exp_q[rows[i].egr * NI + p].push_back(
                            {(b == rows[i].len - 1), beat_word(i, b)});
                    end
                    exp_egr[rows[i].egr]++;
                    port_fwd[p] = 1'b1;
                end else begin
                    exp_drop[p]++;
                end
                if (rows[i].stall) stall_egr = 1'b1;
            end
        end
        fwd_ports = 0;
        for (int i = 0; i < NI; i++) begin
            fwd_ports += port_fwd[i] ? 1 : 0;
        end
        alt_on = (fwd_ports > 1);
        for (int e = 0; e < NE; e++) begin
            prev_ok[e] = 1'b0;
        end

        cycles   = 0;
        accepted = 0;
        finished = 1'b0;
        while (!finished && cycles < LIMIT) begin
            @(posedge clk);
            finished = 1'b1;
            for (int i = 0; i < NI; i++) begin
                if (pidx[i] < pcnt[i]) begin
                    r = prow[i][pidx[i]];
                    finished = 1'b0;
                    // Stalled dropped packets wait for a full buffer
                    if (rows[r].stall && !rows[r].en && beat[i] == 0 &&
                        accepted < `ROUTER_FIFO_DEPTH) begin
                        ing_valid[i] <= 1'b0;
                        ing_last[i]  <= 1'b0;
                    end else begin
                        ing_valid[i] <= 1'b1;
                        ing_data[i]  <= beat_word(r, beat[i]);
                        ing_last[i]  <= (beat[i] == rows[r].len - 1);
                    end
                end else begin
                    ing_valid[i] <= 1'b0;
                    ing_last[i]  <= 1'b0;
                end
            end
            if (!finished) begin
                @(negedge clk);
                for (int i = 0; i < NI; i++) begin
                    if (ing_valid[i]) begin
                        r = prow[i][pidx[i]];
                        // A lone dropped packet must never see back-pressure
                        if (!rows[r].en && ing_valid == NI'(1 << i)) begin
                            assert (ing_ready[i])
                                else log_failure($sformatf("dropped packet %0d stalled", r));
                        end
                        if (stall_egr && rows[r].en && accepted == `ROUTER_FIFO_DEPTH) begin
                            assert (!ing_ready[i])
                                else log_failure("ingress ready high with a full buffer");
                            stall_egr = 1'b0;
                        end
                        if (ing_ready[i]) begin
                            accepted += rows[r].en ? 1 : 0;
                            beat[i]++;
                            if (beat[i] == rows[r].len) begin
                                beat[i] = 0;
                                pidx[i]++;
                            end
                        end
                    end
                end
            end
            cycles++;
        end
        stall_egr = 1'b0;
        if (!finished) begin
            $display("Timeout: ingress did not take packet group %0d within %0d cycles",
                     g, LIMIT);
            timeouts++;
            ing_valid <= '0;
        end
    endtask

    //////////////////////////////
    // Egress monitor

    always @(negedge clk) begin
        if (rst_n) begin
            for (int e = 0; e < NE; e++) begin
                if (egr_valid[e] && egr_ready[e]) begin
                    mon_row = int'(egr_data[e][DW-1:16]);
                    assert (mon_row < nrows)
                        else log_failure($sformatf("unknown packet on egress %0d", e));
                    if (mon_row < nrows) begin
                        mon_src = rows[mon_row].port;
                        if (in_pkt[e]) begin
                            assert (mon_src == cur_src[e])
                                else log_failure($sformatf("packets interleaved on egress %0d", e));
                        end else if (alt_on && prev_ok[e]) begin
                            assert (mon_src != prev_src[e])
                                else log_failure($sformatf("ingress %0d granted twice", mon_src));
                        end
                        assert (exp_q[e*NI + mon_src].size() != 0)
                            else log_failure($sformatf("unexpected beat 0x%0h on egress %0d",
                                                       egr_data[e], e));
                        if (exp_q[e*NI + mon_src].size() != 0) begin
                            mon_exp = exp_q[e*NI + mon_src].pop_front();
                            assert ({egr_last[e], egr_data[e]} == mon_exp)
                                else log_failure($sformatf("egress %0d beat %0h, expected %0h",
                                                           e, {egr_last[e], egr_data[e]}, mon_exp));
                        end
                        in_pkt[e]  = !egr_last[e];
                        cur_src[e] = mon_src;
                        if (egr_last[e]) begin
                            prev_src[e] = mon_src;
                            prev_ok[e]  = 1'b1;
                        end
                    end
                end
            end
        end
    end

    //////////////////////////////
    // Main sequence

    initial begin
        errors    = 0;
        timeouts  = 0;
        nrows     = 0;
        stall_egr = 1'b0;
        alt_on    = 1'b0;
        for (int e = 0; e < NE; e++) begin
            in_pkt[e]  = 1'b0;
            prev_ok[e] = 1'b0;
            exp_egr[e] = 0;
        end
        for (int p = 0; p < NI; p++) begin
            exp_drop[p] = 0;
        end
        rst_n     <= 1'b0;
        ing_data  <= '0;
        ing_last  <= '0;
        ing_valid <= '0;
        csr_wr    <= 1'b0;
        csr_rd    <= 1'b0;
        csr_addr  <= '0;
        csr_wdata <= '0;

        //      grp port len en egr stall
        add_row(0,  0,   3,  1, 1,  0);
        add_row(1,  1,   2,  1, 0,  0);
        add_row(2,  0,   4,  0, 0,  0);
        add_row(3,  1,   1,  0, 1,  0);
        // Both ports busy, same egress
        add_row(4,  0,   5,  1, 0,  0);
        add_row(4,  0,   2,  1, 0,  0);
        add_row(4,  1,   3,  1, 0,  0);
        add_row(4,  1,   6,  1, 0,  0);
        // Fills the buffer while the egress is held off
        add_row(5,  0,   6,  1, 1,  1);
        add_row(5,  0,   6,  1, 1,  1);
        add_row(5,  0,   6,  1, 1,  1);
        add_row(6,  1,   4,  1, 1,  0);
        add_row(6,  0,   2,  0, 0,  0);
        add_row(7,  1,   6,  1, 0,  0);
        // Dropped packet against a full buffer
        add_row(8,  0,   6,  1, 0,  1);
        add_row(8,  0,   6,  1, 0,  1);
        add_row(8,  0,   4,  1, 0,  1);
        add_row(8,  1,   3,  0, 0,  1);

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (egr_valid == '0) else log_failure("egress valid high after reset");
        assert (!csr_rvalid) else log_failure("read valid high after reset");
        for (int p = 0; p < NI; p++) begin
            csr_check(csr_addr_e'(FWD_ING0 + p), '0, $sformatf("reset entry %0d", p));
        end
        check_counters();

        for (int g = 0; g < NGRP; g++) begin
            run_group(g);
            wait_drain(g);
            check_counters();
        end

        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/router_csr.sv
// Forwarding table and counters

`timescale 1ns/100ps
`default_nettype none

`include "router_params.svh"

module router_csr
    import router_csr_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                csr_wr,
    input  logic                                csr_rd,
    input  csr_addr_e                           csr_addr,
    input  logic [`ROUTER_DATA_W-1:0]           csr_wdata,
    output logic [`ROUTER_DATA_W-1:0]           csr_rdata,
    output logic                                csr_rvalid,
    output fwd_entry_t [`ROUTER_NUM_ING-1:0]    fwd_table,
    input  logic [`ROUTER_NUM_EGR-1:0]          done,
    input  logic [`ROUTER_NUM_ING-1:0]          drop
);

    localparam int NI = `ROUTER_NUM_ING;
    localparam int NE = `ROUTER_NUM_EGR;
    localparam int DW = `ROUTER_DATA_W;
    localparam int FW = $bits(fwd_entry_t);

    logic [NE-1:0][`ROUTER_CNT_W-1:0] egr_cnt;
    logic [NI-1:0][`ROUTER_CNT_W-1:0] drop_cnt;
    logic [DW-1:0]                    rd_mux;

    //////////////////////////////
    // Writes and counters

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fwd_table <= '0;
            egr_cnt   <= '0;
            drop_cnt  <= '0;
        end else begin
            for (int i = 0; i < NI; i++) begin
                if (csr_wr && csr_addr == csr_addr_e'(FWD_ING0 + i)) begin
                    fwd_table[i] <= fwd_entry_t'(csr_wdata[FW-1:0]);
                end
                if (drop[i]) drop_cnt[i] <= drop_cnt[i] + 1'b1;
            end
            // Wrapping packet counts
            for (int i = 0; i < NE; i++) begin
                if (done[i]) egr_cnt[i] <= egr_cnt[i] + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Reads

    // Each register bank starts at its enum base address
    always_comb begin
        rd_mux = '0;
        for (int i = 0; i < NI; i++) begin
            if (csr_addr == csr_addr_e'(FWD_ING0 + i))  rd_mux = DW'(fwd_table[i]);
            if (csr_addr == csr_addr_e'(DROP_CNT0 + i)) rd_mux = DW'(drop_cnt[i]);
        end
        for (int i = 0; i < NE; i++) begin
            if (csr_addr == csr_addr_e'(EGR_CNT0 + i)) rd_mux = DW'(egr_cnt[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (csr_rd) csr_rdata <= rd_mux;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) csr_rvalid <= 1'b0;
        else        csr_rvalid <= csr_rd;
    end

endmodule

`default_nettype wire

//--- hdl/router_csr_pkg.sv
// Router register types

`default_nettype none

package router_csr_pkg;

    import router_stream_pkg::*;

    // Register map
    typedef enum logic [3:0] {
        FWD_ING0  = 4'd0,
        FWD_ING1  = 4'd1,
        EGR_CNT0  = 4'd4,
        EGR_CNT1  = 4'd5,
        DROP_CNT0 = 4'd8,
        DROP_CNT1 = 4'd9
    } csr_addr_e;

    // One forwarding table entry per ingress port
    typedef struct packed {
        logic      en;
        egr_port_t egr;
    } fwd_entry_t;

endpackage

`default_nettype wire

//--- hdl/router_egress.sv
// Egress port demultiplexer

`timescale 1ns/100ps
`default_nettype none

`include "router_params.svh"

module router_egress
    import router_stream_pkg::*;
(
    stream_if.sink                                          in,
    output logic [`ROUTER_NUM_EGR-1:0][`ROUTER_DATA_W-1:0]  egr_data,
    output logic [`ROUTER_NUM_EGR-1:0]                      egr_last,
    output logic [`ROUTER_NUM_EGR-1:0]                      egr_valid,
    input  logic [`ROUTER_NUM_EGR-1:0]                      egr_ready,
    output logic [`ROUTER_NUM_EGR-1:0]                      done
);

    localparam int NE = `ROUTER_NUM_EGR;

    logic [NE-1:0] port_sel;

    //////////////////////////////
    // Steering

    always_comb begin
        for (int i = 0; i < NE; i++) begin
            port_sel[i]  = (in.dest == egr_port_t'(i));
            // Payload fans out to every port, valid only to the chosen one
            egr_data[i]  = in.data;
            egr_last[i]  = in.last;
            egr_valid[i] = in.valid && port_sel[i];
            done[i]      = egr_valid[i] && egr_ready[i] && in.last;
        end
    end

    // Back-pressure from the selected port only
    always_comb begin
        in.ready = 1'b0;
        for (int i = 0; i < NE; i++) begin
            if (port_sel[i]) begin
                in.ready = egr_ready[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/router_fifo.sv
// Shared packet buffer

`timescale 1ns/100ps
`default_nettype none

`include "router_params.svh"

module router_fifo
    import router_stream_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    stream_if.sink   wr,
    stream_if.source rd
);

    localparam int DEPTH = `ROUTER_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    logic [`ROUTER_DATA_W-1:0] mem_data [DEPTH];
    logic                      mem_last [DEPTH];
    egr_port_t                 mem_dest [DEPTH];

    // One extra bit tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign wr.ready = !full;
    assign rd.valid = !empty;

    // Show-ahead read of the head entry
    assign rd.data = mem_data[rd_ptr[AW-1:0]];
    assign rd.last = mem_last[rd_ptr[AW-1:0]];
    assign rd.dest = mem_dest[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (wr.valid && !full) begin
            mem_data[wr_ptr[AW-1:0]] <= wr.data;
            mem_last[wr_ptr[AW-1:0]] <= wr.last;
            mem_dest[wr_ptr[AW-1:0]] <= wr.dest;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr.valid && !full) wr_ptr <= wr_ptr + 1'b1;
            if (rd.ready && !empty) rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/router_ingress.sv
// Ingress arbiter with forwarding lookup

`timescale 1ns/100ps
`default_nettype none

`include "router_params.svh"

module router_ingress
    import router_stream_pkg::*;
    import router_csr_pkg::*;
(
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic [`ROUTER_NUM_ING-1:0][`ROUTER_DATA_W-1:0]    ing_data,
    input  logic [`ROUTER_NUM_ING-1:0]                        ing_last,
    input  logic [`ROUTER_NUM_ING-1:0]                        ing_valid,
    output logic [`ROUTER_NUM_ING-1:0]                        ing_ready,
    input  fwd_entry_t [`ROUTER_NUM_ING-1:0]                  fwd_table,
    output logic [`ROUTER_NUM_ING-1:0]                        drop,
    stream_if.source                                          out
);

    localparam int NI = `ROUTER_NUM_ING;
    localparam int PW = `ROUTER_PORT_W;

    arb_state_e  state;
    logic [PW-1:0] rr_ptr;
    logic [PW-1:0] pick;
    logic [PW-1:0] sel;
    logic [PW-1:0] cur_port;
    logic [PW-1:0] next_port;
    fwd_entry_t    cur_entry;
    fwd_entry_t    entry;
    logic          beat_fire;

    //////////////////////////////
    // Port selection

    // First valid port at or after the round-robin pointer
    always_comb begin
        int   idx;
        logic found;
        pick  = rr_ptr;
        found = 1'b0;
        for (int k = 0; k < NI; k++) begin
            idx = (int'(rr_ptr) + k) % NI;
            if (!found && ing_valid[idx]) begin
                pick  = PW'(idx);
                found = 1'b1;
            end
        end
    end

    assign sel       = (state == ARB_PKT) ? cur_port : pick;
    assign next_port = (int'(sel) == NI - 1) ? '0 : sel + 1'b1;

    // Live lookup on the first beat, latched entry afterwards
    assign entry     = (state == ARB_PKT) ? cur_entry : fwd_table[sel];

    // Disabled packets are swallowed without waiting on the buffer
    assign beat_fire = ing_valid[sel] && (!entry.en || out.ready);

    assign out.data  = ing_data[sel];
    assign out.last  = ing_last[sel];
    assign out.dest  = entry.egr;
    assign out.valid = ing_valid[sel] && entry.en;

    always_comb begin
        for (int i = 0; i < NI; i++) begin
            ing_ready[i] = (sel == PW'(i)) && (!entry.en || out.ready);
            drop[i]      = (sel == PW'(i)) && beat_fire && ing_last[sel] && !entry.en;
        end
    end

    //////////////////////////////
    // Arbiter state

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= ARB_IDLE;
            rr_ptr <= '0;
        end else if (beat_fire && ing_last[sel]) begin
            state  <= ARB_IDLE;
            rr_ptr <= next_port;
        end else if (beat_fire) begin
            state  <= ARB_PKT;
        end else if (state == ARB_IDLE && ing_valid[sel]) begin
            // Stalled first beat keeps its grant
            rr_ptr <= sel;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && beat_fire) begin
            cur_port  <= sel;
            cur_entry <= entry;
        end
    end

endmodule

`default_nettype wire

//--- hdl/router_stream_pkg.sv
// Router stream types

`default_nettype none

package router_stream_pkg;

`include "router_params.svh"

    // Egress port index carried on the stream dest field
    typedef logic [`ROUTER_PORT_W-1:0] egr_port_t;

    // Packet arbiter states
    typedef enum logic {
        ARB_IDLE,
        ARB_PKT
    } arb_state_e;

endpackage

`default_nettype wire

//--- hdl/router_top.sv
// Packet router core
// Two ingress streams, shared buffer, two egress streams

`timescale 1ns/100ps
`default_nettype none

`include "router_params.svh"

module router_top
    import router_csr_pkg::*;
(
    input  logic                                            clk,
    input  logic                                            rst_n,

    input  logic [`ROUTER_NUM_ING-1:0][`ROUTER_DATA_W-1:0]  ing_data,
    input  logic [`ROUTER_NUM_ING-1:0]                      ing_last,
    input  logic [`ROUTER_NUM_ING-1:0]                      ing_valid,
    output logic [`ROUTER_NUM_ING-1:0]                      ing_ready,

    output logic [`ROUTER_NUM_EGR-1:0][`ROUTER_DATA_W-1:0]  egr_data,
    output logic [`ROUTER_NUM_EGR-1:0]                      egr_last,
    output logic [`ROUTER_NUM_EGR-1:0]                      egr_valid,
    input  logic [`ROUTER_NUM_EGR-1:0]                      egr_ready,

    input  logic                                            csr_wr,
    input  logic                                            csr_rd,
    input  logic [$bits(csr_addr_e)-1:0]                    csr_addr,
    input  logic [`ROUTER_DATA_W-1:0]                       csr_wdata,
    output logic [`ROUTER_DATA_W-1:0]                       csr_rdata,
    output logic                                            csr_rvalid
);

    fwd_entry_t [`ROUTER_NUM_ING-1:0] fwd_table;
    logic [`ROUTER_NUM_ING-1:0]       drop;
    logic [`ROUTER_NUM_EGR-1:0]       done;

    stream_if ing_to_buf ();
    stream_if buf_to_egr ();

    //////////////////////////////
    // Datapath

    router_ingress u_ingress (
        .clk       ( clk        ),
        .rst_n     ( rst_n      ),
        .ing_data  ( ing_data   ),
        .ing_last  ( ing_last   ),
        .ing_valid ( ing_valid  ),
        .ing_ready ( ing_ready  ),
        .fwd_table ( fwd_table  ),
        .drop      ( drop       ),
        .out       ( ing_to_buf )
    );

    router_fifo u_fifo (
        .clk   ( clk        ),
        .rst_n ( rst_n      ),
        .wr    ( ing_to_buf ),
        .rd    ( buf_to_egr )
    );

    router_egress u_egress (
        .in        ( buf_to_egr ),
        .egr_data  ( egr_data   ),
        .egr_last  ( egr_last   ),
        .egr_valid ( egr_valid  ),
        .egr_ready ( egr_ready  ),
        .done      ( done       )
    );

    //////////////////////////////
    // Registers

    router_csr u_csr (
        .clk        ( clk                    ),
        .rst_n      ( rst_n                  ),
        .csr_wr     ( csr_wr                 ),
        .csr_rd     ( csr_rd                 ),
        .csr_addr   ( csr_addr_e'(csr_addr)  ),
        .csr_wdata  ( csr_wdata              ),
        .csr_rdata  ( csr_rdata              ),
        .csr_rvalid ( csr_rvalid             ),
        .fwd_table  ( fwd_table              ),
        .done       ( done                   ),
        .drop       ( drop                   )
    );

endmodule

`default_nettype wire

//--- hdl/stream_if.sv
// Packet stream interface

`timescale 1ns/100ps
`default_nettype none

`include "router_params.svh"

interface stream_if
    import router_stream_pkg::*;
();

    logic [`ROUTER_DATA_W-1:0] data;
    logic                      last;
    egr_port_t                 dest;
    logic                      valid;
    logic                      ready;

    modport source (output data, last, dest, valid, input ready);
    modport sink   (input data, last, dest, valid, output ready);

endinterface

`default_nettype wire

//--- include/router_params.svh
// Router core sizes

`ifndef ROUTER_PARAMS_SVH
`define ROUTER_PARAMS_SVH

// Width of one data beat
`define ROUTER_DATA_W      32

// Port counts
`define ROUTER_NUM_ING     2
`define ROUTER_NUM_EGR     2
`define ROUTER_PORT_W      1

// Shared buffer depth, must be a power of two
`define ROUTER_FIFO_DEPTH  16

`define ROUTER_CNT_W       16

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the router testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module router_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vrouter_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1

//--- src.f
+incdir+include
hdl/router_stream_pkg.sv
hdl/router_csr_pkg.sv
hdl/stream_if.sv
hdl/router_ingress.sv
hdl/router_fifo.sv
hdl/router_egress.sv
hdl/router_csr.sv
hdl/router_top.sv
bench/router_tb.sv
